// File: build.f
+incdir+.
flash_pkg.sv
uart_pkg.sv
spi_flash_reader.sv
dump_sequencer.sv
uart_tx.sv
hex_dump.sv
tb_models.sv
tb_hex_dump.sv

// File: dump_sequencer.sv
`include "hex_dump_params.svh"

module dump_sequencer (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   rd_data_available,
   input  flash_pkg::flash_word_u rd_data,
   output logic                   rd_ack,
   input  logic                   tx_busy,
   output logic                   tx_start,
   output logic [7:0]             tx_dat,
   output logic                   done
);

   localparam int CNT_W = $clog2(`DUMP_BYTES);

   logic [1:0]       byte_idx;   // byte of the current word
   logic [CNT_W-1:0] byte_cnt;   // bytes started so far
   logic             wait_busy;  // frame started but busy not seen yet
   logic             send;

   assign send = rd_data_available && !tx_busy && !wait_busy && !done;

   always_ff @(posedge clk) begin
      if (rst) begin
         byte_idx  <= '0;
         byte_cnt  <= '0;
         wait_busy <= 1'b0;
         rd_ack    <= 1'b0;
         tx_start  <= 1'b0;
         done      <= 1'b0;
      end else begin
         rd_ack   <= 1'b0;
         tx_start <= 1'b0;

         if (wait_busy && tx_busy) begin
            wait_busy <= 1'b0;   // transmitter has taken the byte
         end

         if (send) begin
            tx_start  <= 1'b1;
            wait_busy <= 1'b1;
            byte_idx  <= byte_idx + 2'd1;
            byte_cnt  <= byte_cnt + 1'b1;
            if (byte_idx == 2'd3) begin
               rd_ack <= 1'b1;   // word fully handed out
            end
            if (byte_cnt == CNT_W'(`DUMP_BYTES - 1)) begin
               done <= 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (send) begin
         tx_dat <= rd_data.bytes[byte_idx];
      end
   end

   // a frame is only started into an idle transmitter
   a_start_when_idle: assert property (@(posedge clk) disable iff (rst)
      tx_start |-> !tx_busy)
      else $error("tx_start while the transmitter is busy");

endmodule

// File: flash_pkg.sv
package flash_pkg;

   // one buffered read word from the flash
   // word holds the four bytes little endian, so the first byte read from
   // the flash sits in bits 7:0 and in bytes[0]
   typedef union packed {
      logic [31:0]     word;   // written by the reader
      logic [3:0][7:0] bytes;  // read by the sequencer
   } flash_word_u;

   // spi read transaction phases
   typedef enum logic [2:0] {
      RD_IDLE,   // waiting to start after reset
      RD_CMD,    // opcode bits
      RD_ADDR,   // 24 address bits
      RD_DATA,   // streaming words
      RD_HOLD    // ss released, wait for reset
   } reader_state_e;

endpackage

// File: hex_dump.sv
module hex_dump (
   input  logic clk,
   input  logic rst,
   output logic fpga_tx,
   output logic SPI_SCK,
   output logic SPI_SS,
   output logic SPI_MOSI,
   input  logic SPI_MISO
);

   flash_pkg::flash_word_u rd_data;

   logic       rd_data_available;
   logic       rd_ack;
   logic       done;
   logic       tx_start;
   logic       tx_busy;
   logic [7:0] tx_dat;

   spi_flash_reader reader_inst (
      .clk               (clk),
      .rst               (rst),
      .done              (done),
      .rd_ack            (rd_ack),
      .rd_data_available (rd_data_available),
      .rd_data           (rd_data),
      .SPI_SCK           (SPI_SCK),
      .SPI_SS            (SPI_SS),
      .SPI_MOSI          (SPI_MOSI),
      .SPI_MISO          (SPI_MISO)
   );

   dump_sequencer seq_inst (
      .clk               (clk),
      .rst               (rst),
      .rd_data_available (rd_data_available),
      .rd_data           (rd_data),
      .rd_ack            (rd_ack),
      .tx_busy           (tx_busy),
      .tx_start          (tx_start),
      .tx_dat            (tx_dat),
      .done              (done)
   );

   uart_tx tx_inst (
      .clk       (clk),
      .rst       (rst),
      .tx_start  (tx_start),
      .tx_dat    (tx_dat),
      .tx_serial (fpga_tx),
      .tx_busy   (tx_busy)
   );

endmodule

// File: hex_dump_params.svh
`ifndef HEX_DUMP_PARAMS_SVH
`define HEX_DUMP_PARAMS_SVH

// system clocks per uart bit, small for simulation
`define CLKS_PER_BIT 16

// bytes sent over the uart, keep a multiple of 4
`define DUMP_BYTES 256

`define DUMP_START_ADDR 24'h000000   // first flash byte dumped

`define FLASH_READ_OP 8'h03          // plain read, no dummy cycles

`endif

// File: run_sim.sh
#!/bin/sh
# build the hex dump testbench with verilator, run it and grep the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_hex_dump \
   -f build.f -Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/Vtb_hex_dump > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "\*\*\* TEST PASSED \*\*\*" "$LOG"; then
   exit 0
fi
exit 1

// File: spi_flash_reader.sv
`include "hex_dump_params.svh"

module spi_flash_reader (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   done,
   input  logic                   rd_ack,
   output logic                   rd_data_available,
   output flash_pkg::flash_word_u rd_data,
   output logic                   SPI_SCK,
   output logic                   SPI_SS,
   output logic                   SPI_MOSI,
   input  logic                   SPI_MISO
);

   localparam logic [31:0] CMD_WORD = {`FLASH_READ_OP, `DUMP_START_ADDR};

   flash_pkg::reader_state_e state;

   logic        start_dly;   // one cycle gap after reset
   logic [4:0]  bit_cnt;
   logic [31:0] cmd_sr;      // opcode and address msb first
   logic [31:0] data_sr;
   logic [31:0] next_sr;

   // shift register value including the bit sampled this cycle
   assign next_sr = {data_sr[30:0], SPI_MISO};

   always_ff @(posedge clk) begin
      if (rst) begin
         state             <= flash_pkg::RD_IDLE;
         start_dly         <= 1'b0;
         bit_cnt           <= '0;
         rd_data_available <= 1'b0;
         SPI_SCK           <= 1'b0;
         SPI_SS            <= 1'b1;
         SPI_MOSI          <= 1'b0;
      end else begin
         start_dly <= 1'b1;

         if (rd_ack) begin
            rd_data_available <= 1'b0;   // buffer free next cycle
         end

         case (state)
            flash_pkg::RD_IDLE: begin
               if (start_dly) begin
                  SPI_SS   <= 1'b0;
                  cmd_sr   <= CMD_WORD;
                  SPI_MOSI <= CMD_WORD[31];   // first bit set up before sck rises
                  bit_cnt  <= '0;
                  state    <= flash_pkg::RD_CMD;
               end
            end

            flash_pkg::RD_CMD, flash_pkg::RD_ADDR: begin
               if (!SPI_SCK) begin
                  SPI_SCK <= 1'b1;
               end else begin
                  // falling edge moves mosi to the next bit
                  SPI_SCK  <= 1'b0;
                  cmd_sr   <= {cmd_sr[30:0], 1'b0};
                  SPI_MOSI <= cmd_sr[30];
                  bit_cnt  <= bit_cnt + 5'd1;
                  if (bit_cnt == 5'd7) begin
                     state <= flash_pkg::RD_ADDR;
                  end
                  if (bit_cnt == 5'd31) begin
                     SPI_MOSI <= 1'b0;
                     state    <= flash_pkg::RD_DATA;
                  end
               end
            end

            flash_pkg::RD_DATA: begin
               if (!SPI_SCK) begin
                  if (done) begin
                     SPI_SS <= 1'b1;   // end the continuous read
                     state  <= flash_pkg::RD_HOLD;
                  end else if (bit_cnt != 5'd0 || !rd_data_available) begin
                     SPI_SCK <= 1'b1;  // sck stays low while the buffer is full
                  end
               end else begin
                  // miso is still stable from the last falling edge
                  SPI_SCK <= 1'b0;
                  data_sr <= next_sr;
                  bit_cnt <= bit_cnt + 5'd1;
                  if (bit_cnt == 5'd31) begin
                     rd_data.word      <= {next_sr[7:0], next_sr[15:8],
                                           next_sr[23:16], next_sr[31:24]};
                     rd_data_available <= 1'b1;
                  end
               end
            end

            flash_pkg::RD_HOLD: begin
               SPI_SS  <= 1'b1;
               SPI_SCK <= 1'b0;
            end

            default: begin
               state <= flash_pkg::RD_IDLE;
            end
         endcase
      end
   end

   // the sequencer only acks a word that the reader still holds
   a_ack_with_data: assert property (@(posedge clk) disable iff (rst)
      rd_ack |-> rd_data_available)
      else $error("rd_ack seen while no word was buffered");

endmodule

// File: tb_hex_dump.sv
`include "hex_dump_params.svh"

module tb_hex_dump;

   localparam int MEM_BYTES    = 4096;
   localparam int FRAME_CLKS   = 10 * `CLKS_PER_BIT;
   localparam int ABORT_BYTES  = 10;   // bytes of the dump cut short by reset
   localparam int QUIET_CYCLES = 20 * FRAME_CLKS;
   localparam int DUMP_CYCLES  = (`DUMP_BYTES + 8) * FRAME_CLKS * 2;
   localparam int RESET_TEST_CYCLES = 3 * 8 + (ABORT_BYTES + `DUMP_BYTES + 8) * FRAME_CLKS * 2;
   localparam int WATCHDOG_CYCLES   = DUMP_CYCLES + RESET_TEST_CYCLES;

   logic        clk;
   logic        rst;
   logic        fpga_tx;
   logic        SPI_SCK;
   logic        SPI_SS;
   logic        SPI_MOSI;
   logic        SPI_MISO;
   logic [31:0] cmd_word;
   logic [7:0]  rx_byte;
   logic        rx_frame_ok;
   logic [31:0] rx_count;

   logic [7:0] ref_mem [0:MEM_BYTES-1];   // expected flash contents
   int         checks;
   int         value_errors;
   int         other_errors;

   hex_dump UUT (
      .clk      (clk),
      .rst      (rst),
      .fpga_tx  (fpga_tx),
      .SPI_SCK  (SPI_SCK),
      .SPI_SS   (SPI_SS),
      .SPI_MOSI (SPI_MOSI),
      .SPI_MISO (SPI_MISO)
   );

   flash_model #(.MEM_BYTES(MEM_BYTES)) flash (
      .SPI_SCK  (SPI_SCK),
      .SPI_SS   (SPI_SS),
      .SPI_MOSI (SPI_MOSI),
      .SPI_MISO (SPI_MISO),
      .cmd_word (cmd_word)
   );

   uart_monitor monitor (
      .clk         (clk),
      .rx          (fpga_tx),
      .rx_byte     (rx_byte),
      .rx_frame_ok (rx_frame_ok),
      .rx_count    (rx_count)
   );

   always begin
      #4 clk = ~clk;
   end

   function automatic logic [31:0] next_random(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic check(input string name, input logic [31:0] expected,
                        input logic [31:0] actual);
      checks++;
      if (expected !== actual) begin
         value_errors++;
         $display("error %s expected %h actual %h", name, expected, actual);
      end
   endtask

   task automatic check_idle_pins(input string tag);
      check({tag, " fpga_tx"}, 32'(1'b1), 32'(fpga_tx));
      check({tag, " SPI_SS"}, 32'(1'b1), 32'(SPI_SS));
      check({tag, " SPI_SCK"}, 32'(1'b0), 32'(SPI_SCK));
   endtask

   task automatic apply_reset();
      int i;
      @(posedge clk);
      #1 rst = 1'b1;
      for (i = 0; i < 5; i++) begin
         @(posedge clk);
         #1;
         check_idle_pins("in reset");
      end
      rst = 1'b0;
      @(posedge clk);
      #1;
      check_idle_pins("after reset");   // command starts one cycle later
   endtask

   task automatic receive_dump(input int n_bytes, input string tag);
      int          idx;
      logic [31:0] seen;
      idx  = 0;
      seen = rx_count;
      while (idx < n_bytes) begin
         @(posedge clk);
         if (rx_count != seen) begin
            seen = rx_count;
            if (idx == 0) begin
               check({tag, " command"}, {`FLASH_READ_OP, `DUMP_START_ADDR}, cmd_word);
            end
            if (!rx_frame_ok) begin
               other_errors++;
               $display("%s: byte %0d arrived with a bad start or stop bit", tag, idx);
            end
            check($sformatf("%s byte %0d", tag, idx),
                  32'(ref_mem[(int'(`DUMP_START_ADDR) + idx) % MEM_BYTES]), 32'(rx_byte));
            idx++;
         end
      end
   endtask

   task automatic check_dump_end(input string tag, input logic [31:0] base);
      int i;
      bit line_moved;
      line_moved = 1'b0;
      while (SPI_SS !== 1'b1) begin
         @(negedge clk);
      end
      for (i = 0; i < QUIET_CYCLES; i++) begin
         @(negedge clk);
         if (fpga_tx !== 1'b1) begin
            line_moved = 1'b1;
         end
      end
      if (line_moved) begin
         other_errors++;
         $display("%s: the serial line left idle after the dump ended", tag);
      end
      check({tag, " byte count"}, 32'(`DUMP_BYTES), rx_count - base);
   endtask

   initial begin : watchdog
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("timeout: the dump did not finish within %0d clock cycles", WATCHDOG_CYCLES);
      $display("checks %0d, value errors %0d, other errors %0d",
               checks, value_errors, other_errors);
      $display("*** TEST FAILED ***");
      $finish;
   end

   initial begin : main_seq
      logic [31:0] state;
      logic [31:0] base;
      int          i;

      clk          = 1'b0;
      rst          = 1'b1;
      checks       = 0;
      value_errors = 0;
      other_errors = 0;

      state = 32'd8;
      for (i = 0; i < MEM_BYTES; i++) begin
         state         = next_random(state);
         ref_mem[i]    = state[7:0];
         flash.mem[i]  = state[7:0];
      end

      apply_reset();
      base = rx_count;
      receive_dump(`DUMP_BYTES, "dump 1");
      check_dump_end("dump 1", base);

      // second dump cut short, third must start over
      apply_reset();
      receive_dump(ABORT_BYTES, "dump 2");
      apply_reset();
      base = rx_count;
      receive_dump(`DUMP_BYTES, "dump 3");
      check_dump_end("dump 3", base);

      $display("checks %0d, value errors %0d, other errors %0d",
               checks, value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

// File: tb_models.sv
`include "hex_dump_params.svh"

// spi flash, mode 0, answers a plain read with bytes from mem
module flash_model #(
   parameter int MEM_BYTES = 4096
) (
   input  logic        SPI_SCK,
   input  logic        SPI_SS,
   input  logic        SPI_MOSI,
   output logic        SPI_MISO,
   output logic [31:0] cmd_word
);

   logic [7:0] mem [0:MEM_BYTES-1];   // loaded by the testbench

   initial begin : serve
      int         bit_cnt;
      int         idx;
      int         addr;
      logic [7:0] cur;

      SPI_MISO = 1'b0;
      cmd_word = '0;
      forever begin
         @(negedge SPI_SS);
         bit_cnt  = 0;
         cmd_word = '0;
         while (SPI_SS === 1'b0) begin
            @(SPI_SCK or SPI_SS);
            if (SPI_SS === 1'b0) begin
               if (SPI_SCK === 1'b1) begin
                  if (bit_cnt < 32) begin
                     cmd_word = {cmd_word[30:0], SPI_MOSI};   // opcode, then address
                  end
                  bit_cnt++;
               end else if (bit_cnt >= 32) begin
                  // next data bit goes out on the falling edge
                  idx  = bit_cnt - 32;
                  addr = (int'(cmd_word[23:0]) + idx / 8) % MEM_BYTES;
                  cur  = mem[addr];
                  #1 SPI_MISO = cur[7 - idx % 8];
               end
            end
         end
      end
   end

endmodule

// 8n1 receiver, samples the line in the middle of each bit
module uart_monitor (
   input  logic        clk,
   input  logic        rx,
   output logic [7:0]  rx_byte,
   output logic        rx_frame_ok,
   output logic [31:0] rx_count
);

   initial begin : receive
      logic [7:0] data;
      logic       start_bit;
      int         i;

      rx_byte     = '0;
      rx_frame_ok = 1'b1;
      rx_count    = '0;
      data        = '0;
      forever begin
         @(negedge rx);
         repeat (`CLKS_PER_BIT / 2) @(negedge clk);
         start_bit = rx;
         for (i = 0; i < 8; i++) begin
            repeat (`CLKS_PER_BIT) @(negedge clk);
            data[i] = rx;   // lsb first
         end
         repeat (`CLKS_PER_BIT) @(negedge clk);
         rx_byte     = data;
         rx_frame_ok = !start_bit && rx;
         rx_count    = rx_count + 32'd1;
      end
   end

endmodule

// File: uart_pkg.sv
package uart_pkg;

   // 8n1 transmitter phases
   typedef enum logic [1:0] {
      TX_IDLE,   // line high, ready for tx_start
      TX_START,  // start bit, line low
      TX_DATA,   // eight data bits, lsb first
      TX_STOP    // stop bit, line high
   } tx_state_e;

endpackage

// File: uart_tx.sv
`include "hex_dump_params.svh"

module uart_tx (
   input  logic       clk,
   input  logic       rst,
   input  logic       tx_start,
   input  logic [7:0] tx_dat,
   output logic       tx_serial,
   output logic       tx_busy
);

   localparam int CW = $clog2(`CLKS_PER_BIT);

   uart_pkg::tx_state_e state;

   logic [CW-1:0] clk_cnt;   // clocks within the current bit
   logic [2:0]    bit_idx;
   logic [7:0]    data_sr;
   logic          bit_end;

   assign bit_end = (clk_cnt == CW'(`CLKS_PER_BIT - 1));

   always_ff @(posedge clk) begin
      if (rst) begin
         state     <= uart_pkg::TX_IDLE;
         clk_cnt   <= '0;
         bit_idx   <= '0;
         tx_serial <= 1'b1;
         tx_busy   <= 1'b0;
      end else begin
         clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;

         case (state)
            uart_pkg::TX_IDLE: begin
               clk_cnt <= '0;
               if (tx_start) begin
                  data_sr   <= tx_dat;
                  tx_serial <= 1'b0;   // start bit
                  tx_busy   <= 1'b1;
                  state     <= uart_pkg::TX_START;
               end
            end

            uart_pkg::TX_START: begin
               if (bit_end) begin
                  tx_serial <= data_sr[0];
                  bit_idx   <= '0;
                  state     <= uart_pkg::TX_DATA;
               end
            end

            uart_pkg::TX_DATA: begin
               if (bit_end) begin
                  data_sr <= data_sr >> 1;
                  bit_idx <= bit_idx + 3'd1;
                  if (bit_idx == 3'd7) begin
                     tx_serial <= 1'b1;   // stop bit
                     state     <= uart_pkg::TX_STOP;
                  end else begin
                     tx_serial <= data_sr[1];
                  end
               end
            end

            uart_pkg::TX_STOP: begin
               if (bit_end) begin
                  tx_busy <= 1'b0;
                  state   <= uart_pkg::TX_IDLE;
               end
            end

            default: begin
               state <= uart_pkg::TX_IDLE;
            end
         endcase
      end
   end

   a_idle_line_high: assert property (@(posedge clk) disable iff (rst)
      (state == uart_pkg::TX_IDLE) |-> (tx_serial && !tx_busy))
      else $error("serial line not idle high between frames");

endmodule
